// File: all.f
src/mmu_pkg.sv
src/mmu_fsm.sv
src/mmu_addr_gen.sv
src/mmu_line_buf.sv
src/mmu_evict_buf.sv
src/mmu.sv
verif/tb_mem_model.sv
verif/tb_mmu.sv

// File: run_sim.sh
#!/bin/sh
# build the mmu testbench with Verilator and run it
# exit status is nonzero when the build or the run fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_mmu \
  --Mdir obj_dir -o tb_mmu
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_mmu
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

exit 0

// File: src/mmu.sv
//////////////////////////////////////////////////
// memory management unit top
// serves IO, instruction and data cache clients
// through one 32-bit bus master port
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mmu import mmu_pkg::*; (
  input  wire      clk,
  input  wire      rst_n_i,
  // IO client
  input  wire      io_access_i,
  input  wire      io_rw_i,
  input  word_t    io_addr_i,
  input  word_t    io_wr_data_i,
  output word_t    io_rd_data_o,
  output logic     io_ack_o,
  // instruction cache
  input  wire      ic_miss_i,
  input  word_t    ic_miss_addr_i,
  output ic_line_t ic_data_fill_o,
  output logic     ic_miss_ack_o,
  // data cache
  input  wire      dc_miss_i,
  input  word_t    dc_miss_addr_i,
  input  wire      dc_evict_i,
  input  word_t    dc_evict_addr_i,
  input  dc_line_t dc_evict_data_i,
  output dc_line_t dc_data_fill_o,
  output logic     dc_miss_ack_o,
  // bus master
  output logic     m_cyc_o,
  output logic     m_we_o,
  output word_t    m_addr_o,
  output word_t    m_data_o,
  input  wire      m_ack_i,
  input  word_t    m_data_i
);

  mmu_state_e state;
  mmu_state_e next_state;
  logic       burst_start;
  logic       last_beat;
  logic       evict_pending;
  logic       writeback_done;
  logic       refill;
  logic       io_sel;
  beat_t      beat;
  word_t      burst_addr;
  word_t      evict_addr;
  word_t      wr_word;
  word_t      io_rd_q;
  ic_line_t   line;

  mmu_fsm u_mmu_fsm (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .io_access_i     (io_access_i),
    .ic_miss_i       (ic_miss_i),
    .dc_miss_i       (dc_miss_i),
    .evict_pending_i (evict_pending),
    .m_ack_i         (m_ack_i),
    .last_beat_i     (last_beat),
    .state_o         (state),
    .next_state_o    (next_state),
    .burst_start_o   (burst_start)
  );

  mmu_addr_gen u_mmu_addr_gen (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .burst_start_i  (burst_start),
    .next_state_i   (next_state),
    .m_ack_i        (m_ack_i),
    .dc_miss_addr_i (dc_miss_addr_i),
    .ic_miss_addr_i (ic_miss_addr_i),
    .evict_addr_i   (evict_addr),
    .burst_addr_o   (burst_addr),
    .beat_o         (beat),
    .last_beat_o    (last_beat)
  );

  mmu_line_buf u_mmu_line_buf (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .m_ack_i  (m_ack_i),
    .refill_i (refill),
    .beat_i   (beat),
    .m_data_i (m_data_i),
    .line_o   (line)
  );

  mmu_evict_buf u_mmu_evict_buf (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .dc_evict_i       (dc_evict_i),
    .evict_addr_i     (dc_evict_addr_i),
    .evict_data_i     (dc_evict_data_i),
    .writeback_done_i (writeback_done),
    .beat_i           (beat),
    .evict_pending_o  (evict_pending),
    .evict_addr_o     (evict_addr),
    .wr_word_o        (wr_word)
  );

  //////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////

  assign io_sel         = (state == IO_XFER);
  assign refill         = (state == DC_RD) || (state == IC_RD);
  assign writeback_done = (state == DC_WR) && m_ack_i && last_beat;

  assign m_cyc_o  = io_sel || refill || (state == DC_WR);
  assign m_we_o   = (state == DC_WR) || (io_sel && io_rw_i);
  assign m_addr_o = io_sel ? io_addr_i : burst_addr;
  assign m_data_o = io_sel ? io_wr_data_i : wr_word;

  //////////////////////////////////////////////////
  // client side
  //////////////////////////////////////////////////

  // IO read word, kept until the next IO read
  always_ff @(posedge clk) begin
    if (io_sel && m_ack_i && !io_rw_i) begin
      io_rd_q <= m_data_i;
    end
  end

  assign io_rd_data_o  = io_rd_q;
  assign io_ack_o      = (state == IO_DONE);
  assign dc_miss_ack_o = (state == DC_ACK);
  assign ic_miss_ack_o = (state == IC_ACK);

  // data line is the low half of the shared buffer
  assign ic_data_fill_o = line;
  assign dc_data_fill_o = line[DC_LINE_WORDS*WORD_W-1:0];

endmodule

`default_nettype wire

// File: src/mmu_addr_gen.sv
//////////////////////////////////////////////////
// burst address generator
// line aligned start address, +4 per word and a
// beat counter with last word detection
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mmu_addr_gen import mmu_pkg::*; (
  input  wire        clk,
  input  wire        rst_n_i,
  input  wire        burst_start_i,
  input  mmu_state_e next_state_i,
  input  wire        m_ack_i,
  input  word_t      dc_miss_addr_i,
  input  word_t      ic_miss_addr_i,
  input  word_t      evict_addr_i,
  output word_t      burst_addr_o,
  output beat_t      beat_o,
  output logic       last_beat_o
);

  // byte offset masks for the two line sizes
  localparam word_t DC_MASK = ~word_t'(DC_LINE_WORDS * (WORD_W / 8) - 1);
  localparam word_t IC_MASK = ~word_t'(IC_LINE_WORDS * (WORD_W / 8) - 1);
  localparam word_t STEP    = word_t'(WORD_W / 8);

  word_t addr_q;
  word_t start_addr;
  beat_t beat_q;
  logic  is_ic_q;

  // start address for the burst about to begin
  always_comb begin
    case (next_state_i)
      DC_WR:   start_addr = evict_addr_i & DC_MASK;
      DC_RD:   start_addr = dc_miss_addr_i & DC_MASK;
      IC_RD:   start_addr = ic_miss_addr_i & IC_MASK;
      default: start_addr = addr_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      addr_q  <= '0;
      beat_q  <= '0;
      is_ic_q <= 1'b0;
    end else if (burst_start_i) begin
      addr_q  <= start_addr;
      beat_q  <= '0;
      is_ic_q <= (next_state_i == IC_RD);
    end else if (m_ack_i) begin
      // step to the next word of the line
      addr_q <= addr_q + STEP;
      beat_q <= beat_q + beat_t'(1);
    end
  end

  assign burst_addr_o = addr_q;
  assign beat_o       = beat_q;
  assign last_beat_o  = is_ic_q ? (beat_q == beat_t'(IC_LINE_WORDS - 1))
                                : (beat_q == beat_t'(DC_LINE_WORDS - 1));

  // no word is still being acked when a burst loads its start address
  a_addr_stable: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    burst_start_i |-> !m_ack_i
  );

endmodule

`default_nettype wire

// File: src/mmu_evict_buf.sv
//////////////////////////////////////////////////
// eviction buffer
// captures line and address on the evict rising
// edge, holds them pending until written back
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mmu_evict_buf import mmu_pkg::*; (
  input  wire      clk,
  input  wire      rst_n_i,
  input  wire      dc_evict_i,
  input  word_t    evict_addr_i,
  input  dc_line_t evict_data_i,
  input  wire      writeback_done_i,
  input  beat_t    beat_i,
  output logic     evict_pending_o,
  output word_t    evict_addr_o,
  output word_t    wr_word_o
);

  logic     evict_q;
  logic     pending_q;
  logic     capture;
  word_t    addr_q;
  dc_line_t line_q;

  // rising edge, ignored while a line is still pending
  assign capture = dc_evict_i && !evict_q && !pending_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      evict_q   <= 1'b0;
      pending_q <= 1'b0;
    end else begin
      evict_q <= dc_evict_i;
      if (capture) begin
        pending_q <= 1'b1;
      end else if (writeback_done_i) begin
        pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      addr_q <= evict_addr_i;
      line_q <= evict_data_i;
    end
  end

  // the capture cycle already counts as pending, so a miss raised
  // together with the evict request cannot win arbitration
  assign evict_pending_o = pending_q || capture;
  assign evict_addr_o    = pending_q ? addr_q : evict_addr_i;

  // word for the current write-back beat
  assign wr_word_o = (beat_i < beat_t'(DC_LINE_WORDS)) ?
                     line_q[beat_i[1:0]*WORD_W +: WORD_W] : '0;

  // write-back only completes for a captured line
  a_hold_pending: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    writeback_done_i |-> pending_q
  );

endmodule

`default_nettype wire

// File: src/mmu_fsm.sv
//////////////////////////////////////////////////
// mmu controller FSM
// fixed priority arbitration between eviction,
// data miss, instruction miss and IO, and burst
// sequencing on the bus ack
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mmu_fsm import mmu_pkg::*; (
  input  wire        clk,
  input  wire        rst_n_i,
  input  wire        io_access_i,
  input  wire        ic_miss_i,
  input  wire        dc_miss_i,
  input  wire        evict_pending_i,
  input  wire        m_ack_i,
  input  wire        last_beat_i,
  output mmu_state_e state_o,
  output mmu_state_e next_state_o,
  output logic       burst_start_o
);

  mmu_state_e state_q;
  mmu_state_e state_d;
  logic       burst_done;

  // last word of a burst has been accepted
  assign burst_done = m_ack_i && last_beat_i;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // eviction goes first so the refill never
        // overwrites a line still waiting to be written
        if (evict_pending_i) begin
          state_d = DC_WR;
        end else if (dc_miss_i) begin
          state_d = DC_RD;
        end else if (ic_miss_i) begin
          state_d = IC_RD;
        end else if (io_access_i) begin
          state_d = IO_XFER;
        end
      end
      IO_XFER: begin
        if (m_ack_i) begin
          state_d = IO_DONE;
        end
      end
      IO_DONE: begin
        state_d = IDLE;
      end
      DC_WR: begin
        // back to idle, a waiting miss is picked up there
        if (burst_done) begin
          state_d = IDLE;
        end
      end
      DC_RD: begin
        if (burst_done) begin
          state_d = DC_ACK;
        end
      end
      DC_ACK: begin
        state_d = IDLE;
      end
      IC_RD: begin
        if (burst_done) begin
          state_d = IC_ACK;
        end
      end
      IC_ACK: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // address generator loads in the idle cycle before a burst
  assign burst_start_o = (state_q == IDLE) &&
                         (state_d inside {DC_WR, DC_RD, IC_RD});

  assign state_o      = state_q;
  assign next_state_o = state_d;

  // state must be a known value once out of reset
  a_state_known: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !$isunknown(state_q)
  );

  // served client drops its request before the next arbitration
  a_io_ack_once: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (state_q == IO_DONE) |=> !io_access_i
  );

  a_dc_ack_once: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (state_q == DC_ACK) |=> !dc_miss_i
  );

  a_ic_ack_once: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (state_q == IC_ACK) |=> !ic_miss_i
  );

endmodule

`default_nettype wire

// File: src/mmu_line_buf.sv
//////////////////////////////////////////////////
// refill line buffer
// collects bus read words by beat index, shared by
// instruction and data refills
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mmu_line_buf import mmu_pkg::*; (
  input  wire      clk,
  input  wire      rst_n_i,
  input  wire      m_ack_i,
  input  wire      refill_i,
  input  beat_t    beat_i,
  input  word_t    m_data_i,
  output ic_line_t line_o
);

  word_t words_q [IC_LINE_WORDS];

  // one slot per beat, written on the word's ack
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < IC_LINE_WORDS; i++) begin
        words_q[i] <= '0;
      end
    end else if (refill_i && m_ack_i) begin
      words_q[beat_i] <= m_data_i;
    end
  end

  //////////////////////////////////////////////////
  // pack into a line, word 0 lowest
  //////////////////////////////////////////////////

  genvar g;
  generate
    for (g = 0; g < IC_LINE_WORDS; g++) begin : g_pack
      assign line_o[g*WORD_W +: WORD_W] = words_q[g];
    end
  endgenerate

endmodule

`default_nettype wire

// File: src/mmu_pkg.sv
//////////////////////////////////////////////////
// mmu shared definitions
// bus word, cache line and beat types, plus the
// controller state encoding
//////////////////////////////////////////////////

`default_nettype none

package mmu_pkg;

  // bus geometry
  localparam int WORD_W        = 32;
  localparam int DC_LINE_WORDS = 4;
  localparam int IC_LINE_WORDS = 8;

  // one bus word, also used for byte addresses
  typedef logic [WORD_W-1:0] word_t;

  // cache lines, word 0 in the low bits
  typedef logic [DC_LINE_WORDS*WORD_W-1:0] dc_line_t;
  typedef logic [IC_LINE_WORDS*WORD_W-1:0] ic_line_t;

  // word index inside a burst
  typedef logic [$clog2(IC_LINE_WORDS)-1:0] beat_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    IO_XFER = 3'd1,
    IO_DONE = 3'd2,
    DC_WR   = 3'd3,
    DC_RD   = 3'd4,
    DC_ACK  = 3'd5,
    IC_RD   = 3'd6,
    IC_ACK  = 3'd7
  } mmu_state_e;

endpackage

`default_nettype wire

// File: verif/tb_mem_model.sv
//////////////////////////////////////////////////
// bus slave memory model
// 4096 words, random ack delay of 0 to 3 cycles
// and a log of every bus access
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import mmu_pkg::*; (
  input  wire   clk,
  input  wire   rst_n_i,
  input  wire   cyc_i,
  input  wire   we_i,
  input  word_t addr_i,
  input  word_t data_i,
  output logic  ack_o,
  output word_t data_o
);

  word_t       mem [4096];
  // access log, wraps after 4096 entries
  word_t       log_addr [4096];
  word_t       log_data [4096];
  logic        log_we [4096];
  int          log_cnt;
  logic        busy;
  int          wait_cnt;
  logic [11:0] idx;

  assign idx = addr_i[13:2];

  // power-up contents, a function of the whole address
  function automatic word_t init_word(word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[12'(i)] = init_word(word_t'(i) << 2);
    end
  end

  always @(posedge clk) begin
    int delay;
    if (!rst_n_i) begin
      ack_o    <= 1'b0;
      busy     <= 1'b0;
      wait_cnt <= 0;
      log_cnt  <= 0;
    end else if (ack_o) begin
      // single cycle ack, master steps its address now
      ack_o <= 1'b0;
      busy  <= 1'b0;
    end else if (cyc_i) begin
      delay = busy ? wait_cnt : int'($urandom % 4);
      if (delay == 0) begin
        ack_o  <= 1'b1;
        busy   <= 1'b0;
        data_o <= mem[idx];
        if (we_i) begin
          mem[idx] <= data_i;
        end
        log_addr[log_cnt[11:0]] <= addr_i;
        log_data[log_cnt[11:0]] <= we_i ? data_i : mem[idx];
        log_we[log_cnt[11:0]]   <= we_i;
        log_cnt                 <= log_cnt + 1;
      end else begin
        busy     <= 1'b1;
        wait_cnt <= delay - 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_mmu.sv
//////////////////////////////////////////////////
// mmu testbench
// drives IO, instruction and data cache clients
// and checks results against a shadow memory
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_mmu import mmu_pkg::*; ();

  localparam int    WAIT_LIMIT = 500;
  localparam word_t DC_ALIGN   = 32'hffff_fff0;
  localparam word_t IC_ALIGN   = 32'hffff_ffe0;

  logic     clk;
  logic     rst_n;
  logic     io_access;
  logic     io_rw;
  word_t    io_addr;
  word_t    io_wr_data;
  word_t    io_rd_data;
  logic     io_ack;
  logic     ic_miss;
  word_t    ic_miss_addr;
  ic_line_t ic_fill;
  logic     ic_ack;
  logic     dc_miss;
  word_t    dc_miss_addr;
  logic     dc_evict;
  word_t    dc_evict_addr;
  dc_line_t dc_evict_data;
  dc_line_t dc_fill;
  logic     dc_ack;
  logic     m_cyc;
  logic     m_we;
  word_t    m_addr;
  word_t    m_wdata;
  logic     m_ack;
  word_t    m_rdata;

  // shadow memory and expected results
  word_t      shadow [4096];
  word_t      exp_io;
  dc_line_t   exp_dc;
  ic_line_t   exp_ic;
  logic       io_check_rd;
  logic [1:0] ack_order [$];

  mmu u_mmu (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .io_access_i     (io_access),
    .io_rw_i         (io_rw),
    .io_addr_i       (io_addr),
    .io_wr_data_i    (io_wr_data),
    .io_rd_data_o    (io_rd_data),
    .io_ack_o        (io_ack),
    .ic_miss_i       (ic_miss),
    .ic_miss_addr_i  (ic_miss_addr),
    .ic_data_fill_o  (ic_fill),
    .ic_miss_ack_o   (ic_ack),
    .dc_miss_i       (dc_miss),
    .dc_miss_addr_i  (dc_miss_addr),
    .dc_evict_i      (dc_evict),
    .dc_evict_addr_i (dc_evict_addr),
    .dc_evict_data_i (dc_evict_data),
    .dc_data_fill_o  (dc_fill),
    .dc_miss_ack_o   (dc_ack),
    .m_cyc_o         (m_cyc),
    .m_we_o          (m_we),
    .m_addr_o        (m_addr),
    .m_data_o        (m_wdata),
    .m_ack_i         (m_ack),
    .m_data_i        (m_rdata)
  );

  tb_mem_model u_mem (
    .clk     (clk),
    .rst_n_i (rst_n),
    .cyc_i   (m_cyc),
    .we_i    (m_we),
    .addr_i  (m_addr),
    .data_i  (m_wdata),
    .ack_o   (m_ack),
    .data_o  (m_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic word_t init_word(word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [11:0] word_idx(word_t addr);
    return addr[13:2];
  endfunction

  function automatic word_t ref_word(word_t addr);
    return shadow[word_idx(addr)];
  endfunction

  function automatic dc_line_t ref_dc_line(word_t addr);
    dc_line_t line;
    for (int i = 0; i < DC_LINE_WORDS; i++) begin
      line[i*WORD_W +: WORD_W] = ref_word((addr & DC_ALIGN) + word_t'(4 * i));
    end
    return line;
  endfunction

  function automatic ic_line_t ref_ic_line(word_t addr);
    ic_line_t line;
    for (int i = 0; i < IC_LINE_WORDS; i++) begin
      line[i*WORD_W +: WORD_W] = ref_word((addr & IC_ALIGN) + word_t'(4 * i));
    end
    return line;
  endfunction

  function automatic word_t rand_addr();
    return word_t'($urandom) & 32'h0000_3fff;
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_dc_line(string name, dc_line_t got, dc_line_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_ic_line(string name, ic_line_t got, ic_line_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // results are checked in the ack cycle of each client
  always @(posedge clk) begin
    if (rst_n) begin
      if (dc_ack) begin
        check_dc_line("dc_data_fill_o", dc_fill, exp_dc);
        ack_order.push_back(2'd0);
      end
      if (ic_ack) begin
        check_ic_line("ic_data_fill_o", ic_fill, exp_ic);
        ack_order.push_back(2'd1);
      end
      if (io_ack) begin
        if (io_check_rd) begin
          check_word("io_rd_data_o", io_rd_data, exp_io);
        end
        ack_order.push_back(2'd2);
      end
    end
  end

  // write-back words must be the first four bus accesses
  task automatic check_evict_log(int base, word_t ev_addr, dc_line_t ev_data);
    logic [11:0] k;
    for (int i = 0; i < DC_LINE_WORDS; i++) begin
      k = 12'(base + i);
      if (u_mem.log_we[k] !== 1'b1) begin
        fail_run("eviction words were not written before the refill read");
      end
      check_word("m_addr_o", u_mem.log_addr[k], (ev_addr & DC_ALIGN) + word_t'(4 * i));
      check_word("m_data_o", u_mem.log_data[k], ev_data[i*WORD_W +: WORD_W]);
    end
    if (u_mem.log_we[12'(base + DC_LINE_WORDS)] !== 1'b0) begin
      fail_run("no refill read followed the eviction write-back");
    end
  endtask

  //////////////////////////////////////////////////
  // clients
  //////////////////////////////////////////////////

  task automatic dc_client(word_t addr, logic ev, word_t ev_addr, dc_line_t ev_data);
    int n;
    dc_miss       <= 1'b1;
    dc_miss_addr  <= addr;
    dc_evict      <= ev;
    dc_evict_addr <= ev_addr;
    dc_evict_data <= ev_data;
    for (n = 0; n < WAIT_LIMIT && !dc_ack; n++) begin
      @(posedge clk);
    end
    if (!dc_ack) begin
      fail_run("timeout waiting for dc_miss_ack_o");
    end
    dc_miss  <= 1'b0;
    dc_evict <= 1'b0;
  endtask

  task automatic ic_client(word_t addr);
    int n;
    ic_miss      <= 1'b1;
    ic_miss_addr <= addr;
    for (n = 0; n < WAIT_LIMIT && !ic_ack; n++) begin
      @(posedge clk);
    end
    if (!ic_ack) begin
      fail_run("timeout waiting for ic_miss_ack_o");
    end
    ic_miss <= 1'b0;
  endtask

  task automatic io_client(logic rw, word_t addr, word_t wdata);
    int n;
    io_access  <= 1'b1;
    io_rw      <= rw;
    io_addr    <= addr;
    io_wr_data <= wdata;
    for (n = 0; n < WAIT_LIMIT && !io_ack; n++) begin
      @(posedge clk);
    end
    if (!io_ack) begin
      fail_run("timeout waiting for io_ack_o");
    end
    io_access <= 1'b0;
  endtask

  // raise the chosen requests in one cycle, then check the ack order
  task automatic run_txn(
    input logic     do_dc,
    input word_t    dc_addr,
    input logic     do_ev,
    input word_t    ev_addr,
    input dc_line_t ev_data,
    input logic     do_ic,
    input word_t    ic_addr,
    input logic     do_io,
    input logic     io_wr,
    input word_t    io_a,
    input word_t    io_wdata
  );
    logic [1:0] exp_order [$];
    int         base;
    // eviction lands in memory before any other transfer
    if (do_ev) begin
      for (int i = 0; i < DC_LINE_WORDS; i++) begin
        shadow[word_idx((ev_addr & DC_ALIGN) + word_t'(4 * i))] = ev_data[i*WORD_W +: WORD_W];
      end
    end
    exp_dc      = ref_dc_line(dc_addr);
    exp_ic      = ref_ic_line(ic_addr);
    exp_io      = ref_word(io_a);
    io_check_rd = do_io && !io_wr;
    if (do_io && io_wr) begin
      shadow[word_idx(io_a)] = io_wdata;
    end
    if (do_dc) exp_order.push_back(2'd0);
    if (do_ic) exp_order.push_back(2'd1);
    if (do_io) exp_order.push_back(2'd2);
    ack_order.delete();
    base = u_mem.log_cnt;
    @(posedge clk);
    fork
      if (do_dc) dc_client(dc_addr, do_ev, ev_addr, ev_data);
      if (do_ic) ic_client(ic_addr);
      if (do_io) io_client(io_wr, io_a, io_wdata);
    join
    @(posedge clk);
    if (ack_order.size() != exp_order.size()) begin
      fail_run("wrong number of client acknowledges");
    end
    foreach (exp_order[i]) begin
      if (ack_order[i] != exp_order[i]) begin
        fail_run("client acknowledges came out of priority order");
      end
    end
    if (do_ev) begin
      check_evict_log(base, ev_addr, ev_data);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [2:0] sel;
    logic       ev;
    dc_line_t   line;
    for (int i = 0; i < 4096; i++) begin
      shadow[12'(i)] = init_word(word_t'(i) << 2);
    end
    rst_n         <= 1'b0;
    io_access     <= 1'b0;
    io_rw         <= 1'b0;
    io_addr       <= '0;
    io_wr_data    <= '0;
    ic_miss       <= 1'b0;
    ic_miss_addr  <= '0;
    dc_miss       <= 1'b0;
    dc_miss_addr  <= '0;
    dc_evict      <= 1'b0;
    dc_evict_addr <= '0;
    dc_evict_data <= '0;
    repeat (10) @(posedge clk);
    // acks and bus cycle are idle out of reset
    check_bit("io_ack_o", io_ack, 1'b0);
    check_bit("ic_miss_ack_o", ic_ack, 1'b0);
    check_bit("dc_miss_ack_o", dc_ack, 1'b0);
    check_bit("m_cyc_o", m_cyc, 1'b0);
    check_bit("m_we_o", m_we, 1'b0);
    rst_n <= 1'b1;
    void'($urandom(32'haa88));
    line = {32'h1111_aaaa, 32'h2222_bbbb, 32'h3333_cccc, 32'h4444_dddd};

    // IO write, then read back the same word
    run_txn(1'b0, '0, 1'b0, '0, '0, 1'b0, '0, 1'b1, 1'b1, 32'h0000_0100, 32'hcafe_f00d);
    run_txn(1'b0, '0, 1'b0, '0, '0, 1'b0, '0, 1'b1, 1'b0, 32'h0000_0100, '0);
    // unaligned instruction miss, data miss alone
    run_txn(1'b0, '0, 1'b0, '0, '0, 1'b1, 32'h0000_1234, 1'b0, 1'b0, '0, '0);
    run_txn(1'b1, 32'h0000_0a38, 1'b0, '0, '0, 1'b0, '0, 1'b0, 1'b0, '0, '0);
    // eviction with its miss, then read the evicted line back
    run_txn(1'b1, 32'h0000_2108, 1'b1, 32'h0000_0a3c, line, 1'b0, '0, 1'b0, 1'b0, '0, '0);
    run_txn(1'b1, 32'h0000_0a34, 1'b0, '0, '0, 1'b0, '0, 1'b0, 1'b0, '0, '0);
    // all three clients in one cycle
    run_txn(1'b1, 32'h0000_0540, 1'b0, '0, '0, 1'b1, 32'h0000_3a0c, 1'b1, 1'b0,
            32'h0000_0a38, '0);

    // random mix
    for (int t = 0; t < 200; t++) begin
      sel  = 3'($urandom % 7) + 3'd1;
      ev   = sel[0] && 1'($urandom);
      line = {$urandom, $urandom, $urandom, $urandom};
      run_txn(sel[0], rand_addr(), ev, rand_addr(), line, sel[1], rand_addr(),
              sel[2], 1'($urandom), rand_addr() & 32'hffff_fffc, word_t'($urandom));
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
